// ==== include/nib_macros.svh ====
// Register count, register index width, data width and nibble steps per word
`ifndef NIB_MACROS_SVH
`define NIB_MACROS_SVH

// Architectural registers, x0 included
`define NIB_NUM_REGS 16
`define NIB_REG_ADDR_BITS 4

`define NIB_XLEN 32

// Nibbles per word, one per sub-cycle
`define NIB_STEPS 8

`endif

// ==== source/nib_pkg.sv ====
// ALU operation enumeration and instruction field, nibble and sub-cycle types
`include "nib_macros.svh"

package nib_pkg;

    // ALU operations handled by the execute stage
    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_OR   = 3'd3,
        ALU_XOR  = 3'd4,
        ALU_SLT  = 3'd5,   // Signed set-less-than
        ALU_SLTU = 3'd6    // Unsigned set-less-than
    } alu_op_e;

    typedef logic [`NIB_REG_ADDR_BITS-1:0] reg_idx_t;

    // Low 12 bits of an I-type immediate
    typedef logic signed [11:0] imm12_t;

    typedef logic [3:0] nibble_t;

    // Sub-cycle counter, one value per nibble of a word
    typedef logic [$clog2(`NIB_STEPS)-1:0] step_t;

endpackage

// ==== source/nib_exec_if.sv ====
// Execution interface with issue, register file and execute modports
`timescale 1ns/100ps

interface nib_exec_if;

    // From issue
    nib_pkg::step_t    counter;     // Free-running sub-cycle
    logic              active;      // Instruction executing this cycle
    logic              pass;        // Second pass of a two-pass op
    nib_pkg::alu_op_e  op;
    nib_pkg::reg_idx_t rs1;
    nib_pkg::reg_idx_t rs2;
    nib_pkg::reg_idx_t rd;
    logic              use_imm;
    nib_pkg::nibble_t  imm_nib;     // Sign-extended immediate, current nibble

    // From register file
    nib_pkg::nibble_t  data_rs1;
    nib_pkg::nibble_t  data_rs2;

    // From execute
    logic              wr_en;
    nib_pkg::nibble_t  data_rd;
    logic              last_pass;   // Current pass finishes the instruction

    modport issue (
        output counter, active, pass, op, rs1, rs2, rd, use_imm, imm_nib,
        input  last_pass
    );

    modport regs (
        input  rs1, rs2, rd, wr_en, data_rd,
        output data_rs1, data_rs2
    );

    modport exec (
        input  counter, active, pass, op, use_imm, imm_nib, data_rs1, data_rs2,
        output wr_en, data_rd, last_pass
    );

endinterface

// ==== source/nib_issue.sv ====
// Issue stage with sub-cycle counter, instruction latch, pass FSM and immediate nibbles
`timescale 1ns/100ps
`include "nib_macros.svh"

module nib_issue (
    input  logic              clk,
    input  logic              rstn,
    input  logic              instr_valid,
    input  nib_pkg::alu_op_e  instr_op,
    input  nib_pkg::reg_idx_t instr_rd,
    input  nib_pkg::reg_idx_t instr_rs1,
    input  nib_pkg::reg_idx_t instr_rs2,
    input  nib_pkg::imm12_t   instr_imm,
    input  logic              instr_use_imm,
    output logic              busy,
    output logic              done,
    nib_exec_if.issue         ex
);

    localparam nib_pkg::step_t LAST_STEP = nib_pkg::step_t'(`NIB_STEPS - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,     // Accepted, waiting for counter wrap
        ST_ACTIVE
    } state_e;

    state_e            state;
    nib_pkg::step_t    step_q;
    logic              pass_q;
    logic              last_step;
    logic              accept;

    nib_pkg::alu_op_e  op_q;
    nib_pkg::reg_idx_t rd_q;
    nib_pkg::reg_idx_t rs1_q;
    nib_pkg::reg_idx_t rs2_q;
    nib_pkg::imm12_t   imm_q;
    logic              use_imm_q;

    assign last_step = (step_q == LAST_STEP);
    assign accept    = instr_valid && (state == ST_IDLE);   // Strobes while busy are dropped

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            step_q <= '0;
            state  <= ST_IDLE;
            pass_q <= 1'b0;
        end else begin
            step_q <= step_q + 1'b1;
            case (state)
                ST_IDLE: begin
                    if (accept) state <= last_step ? ST_ACTIVE : ST_WAIT;
                end
                ST_WAIT: begin
                    if (last_step) state <= ST_ACTIVE;
                end
                ST_ACTIVE: begin
                    if (last_step) begin
                        if (ex.last_pass) begin
                            state  <= ST_IDLE;
                            pass_q <= 1'b0;
                        end else begin
                            pass_q <= 1'b1;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Instruction fields held until done
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q      <= instr_op;
            rd_q      <= instr_rd;
            rs1_q     <= instr_rs1;
            rs2_q     <= instr_rs2;
            imm_q     <= instr_imm;
            use_imm_q <= instr_use_imm;
        end
    end

    // Nibbles 0 to 2 from the field, sign fill above
    always_comb begin
        case (step_q)
            3'd0:    ex.imm_nib = imm_q[3:0];
            3'd1:    ex.imm_nib = imm_q[7:4];
            3'd2:    ex.imm_nib = imm_q[11:8];
            default: ex.imm_nib = {4{imm_q[11]}};
        endcase
    end

    assign ex.counter = step_q;
    assign ex.active  = (state == ST_ACTIVE);
    assign ex.pass    = pass_q;
    assign ex.op      = op_q;
    assign ex.rd      = rd_q;
    assign ex.rs1     = rs1_q;
    assign ex.rs2     = rs2_q;
    assign ex.use_imm = use_imm_q;

    assign busy = (state != ST_IDLE);
    assign done = (state == ST_ACTIVE) && last_step && ex.last_pass;

endmodule

// ==== source/nib_regfile.sv ====
// Nibble-serial register file of rotating words with two reads and one write
`timescale 1ns/100ps
`include "nib_macros.svh"

module nib_regfile (
    input  logic     clk,
    input  logic     rstn,
    nib_exec_if.regs ex
);

    // No storage for x0
    logic [`NIB_XLEN-1:0] regs [1:`NIB_NUM_REGS-1];

    // Every word rotates one nibble per clock, so the bottom
    // nibble always lines up with the sub-cycle counter
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 1; i < `NIB_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 1; i < `NIB_NUM_REGS; i++) begin
                if (ex.wr_en && (ex.rd == nib_pkg::reg_idx_t'(i))) begin
                    regs[i] <= {ex.data_rd, regs[i][`NIB_XLEN-1:4]};   // New nibble rotates in
                end else begin
                    regs[i] <= {regs[i][3:0], regs[i][`NIB_XLEN-1:4]};
                end
            end
        end
    end

    // Current nibble of each source, x0 reads zero
    always_comb begin
        if (ex.rs1 == '0) begin
            ex.data_rs1 = '0;
        end else begin
            ex.data_rs1 = regs[ex.rs1][3:0];
        end

        if (ex.rs2 == '0) begin
            ex.data_rs2 = '0;
        end else begin
            ex.data_rs2 = regs[ex.rs2][3:0];
        end
    end

endmodule

// ==== source/nib_alu_exec.sv ====
// Execute stage with nibble ALU, carry and compare chain, two-pass SLT and writeback
`timescale 1ns/100ps
`include "nib_macros.svh"

module nib_alu_exec (
    input  logic       clk,
    input  logic       rstn,
    nib_exec_if.exec   ex,
    output logic       wb_en,
    output logic [3:0] wb_data
);

    localparam nib_pkg::step_t LAST_STEP = nib_pkg::step_t'(`NIB_STEPS - 1);

    logic             is_set;        // SLT or SLTU
    logic             is_sub;
    logic             first_step;
    logic             top_step;
    nib_pkg::nibble_t b_raw;
    nib_pkg::nibble_t b_in;
    logic             cy;
    logic             cy_in;
    logic [4:0]       sum;
    logic             lt_signed;
    logic             lt_unsigned;
    logic             cmp;           // Compare result, held into pass 1
    nib_pkg::nibble_t alu_out;

    assign is_set     = (ex.op == nib_pkg::ALU_SLT) || (ex.op == nib_pkg::ALU_SLTU);
    assign is_sub     = is_set || (ex.op == nib_pkg::ALU_SUB);
    assign first_step = (ex.counter == '0);
    assign top_step   = (ex.counter == LAST_STEP);

    assign b_raw = ex.use_imm ? ex.imm_nib : ex.data_rs2;
    assign b_in  = is_sub ? ~b_raw : b_raw;     // Subtract as A + ~B + 1
    assign cy_in = first_step ? is_sub : cy;

    assign sum = {1'b0, ex.data_rs1} + {1'b0, b_in} + {4'b0000, cy_in};

    // Only meaningful on the top nibble
    assign lt_unsigned = ~sum[4];                                   // Borrow out
    assign lt_signed   = (ex.data_rs1[3] ^ b_raw[3]) ? ex.data_rs1[3] : sum[3];

    always_comb begin
        case (ex.op)
            nib_pkg::ALU_AND: alu_out = ex.data_rs1 & b_raw;
            nib_pkg::ALU_OR:  alu_out = ex.data_rs1 | b_raw;
            nib_pkg::ALU_XOR: alu_out = ex.data_rs1 ^ b_raw;
            default:          alu_out = sum[3:0];   // ADD, SUB and the SLT subtract
        endcase
    end

    // Carry chain advances every nibble
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cy  <= 1'b0;
            cmp <= 1'b0;
        end else begin
            cy <= sum[4];
            if (ex.active && !ex.pass) begin
                if (first_step) begin
                    cmp <= 1'b0;
                end else if (top_step) begin
                    cmp <= (ex.op == nib_pkg::ALU_SLTU) ? lt_unsigned : lt_signed;
                end
            end
        end
    end

    always_comb begin
        ex.last_pass = !is_set || ex.pass;
        ex.wr_en     = 1'b0;
        ex.data_rd   = '0;
        if (ex.active) begin
            if (!is_set) begin
                ex.wr_en   = 1'b1;
                ex.data_rd = alu_out;
            end else if (ex.pass) begin
                // Compare bit in nibble 0, upper bits zero
                ex.wr_en   = 1'b1;
                ex.data_rd = first_step ? {3'b000, cmp} : 4'b0000;
            end
        end
    end

    // Writeback visible at the top level
    assign wb_en   = ex.wr_en;
    assign wb_data = ex.data_rd;

endmodule

// ==== source/nib_core.sv ====
// Top level joining issue, register file and execute stages
`timescale 1ns/100ps

module nib_core (
    input  logic              clk,
    input  logic              rstn,
    input  logic              instr_valid,     // Single-cycle strobe
    input  nib_pkg::alu_op_e  instr_op,
    input  nib_pkg::reg_idx_t instr_rd,
    input  nib_pkg::reg_idx_t instr_rs1,
    input  nib_pkg::reg_idx_t instr_rs2,
    input  nib_pkg::imm12_t   instr_imm,
    input  logic              instr_use_imm,
    output logic              busy,
    output logic              done,            // One cycle, last nibble of final pass
    output logic              wb_en,
    output logic [3:0]        wb_data
);

    nib_exec_if ex_if ();

    nib_issue issue_i (
        .clk           (clk),
        .rstn          (rstn),
        .instr_valid   (instr_valid),
        .instr_op      (instr_op),
        .instr_rd      (instr_rd),
        .instr_rs1     (instr_rs1),
        .instr_rs2     (instr_rs2),
        .instr_imm     (instr_imm),
        .instr_use_imm (instr_use_imm),
        .busy          (busy),
        .done          (done),
        .ex            (ex_if.issue)
    );

    nib_regfile regfile_i (
        .clk  (clk),
        .rstn (rstn),
        .ex   (ex_if.regs)
    );

    nib_alu_exec alu_exec_i (
        .clk     (clk),
        .rstn    (rstn),
        .ex      (ex_if.exec),
        .wb_en   (wb_en),
        .wb_data (wb_data)
    );

endmodule

// ==== dv/nib_core_assert.sv ====
// Concurrent assertions on the strobe, busy, done and writeback protocol
`timescale 1ns/100ps

module nib_core_assert (
    input logic clk,
    input logic rstn,
    input logic instr_valid,
    input logic busy,
    input logic done,
    input logic wb_en
);

    int unsigned fail_count = 0;

    // Done is one cycle wide, busy drops right after it
    done_pulse: assert property (@(posedge clk) disable iff (!rstn)
        done |-> busy ##1 (!done && !busy))
        else begin
            $error("done not a single cycle ending the busy window");
            fail_count++;
        end

    wb_in_busy: assert property (@(posedge clk) disable iff (!rstn)
        wb_en |-> busy)
        else begin
            $error("wb_en high while not busy");
            fail_count++;
        end

    // Strobe during busy is dropped, the in-flight instruction keeps running
    strobe_dropped: assert property (@(posedge clk) disable iff (!rstn)
        (instr_valid && busy && !done) |=> busy)
        else begin
            $error("strobe while busy disturbed the in-flight instruction");
            fail_count++;
        end

    busy_from_strobe: assert property (@(posedge clk) disable iff (!rstn)
        $rose(busy) |-> $past(instr_valid))
        else begin
            $error("busy rose without a strobe");
            fail_count++;
        end

endmodule

bind nib_core nib_core_assert core_assert_i (
    .clk         (clk),
    .rstn        (rstn),
    .instr_valid (instr_valid),
    .busy        (busy),
    .done        (done),
    .wb_en       (wb_en)
);

// ==== dv/nib_core_checker.sv ====
// Checker with a register model, writeback nibble collection and per-instruction compare
`timescale 1ns/100ps
`include "nib_macros.svh"

module nib_core_checker (
    input logic              clk,
    input logic              rstn,
    input logic              instr_valid,
    input nib_pkg::alu_op_e  instr_op,
    input nib_pkg::reg_idx_t instr_rd,
    input nib_pkg::reg_idx_t instr_rs1,
    input nib_pkg::reg_idx_t instr_rs2,
    input nib_pkg::imm12_t   instr_imm,
    input logic              instr_use_imm,
    input logic              busy,
    input logic              done,
    input logic              wb_en,
    input logic [3:0]        wb_data
);

    logic [`NIB_XLEN-1:0] model [`NIB_NUM_REGS];   // x0 never written
    logic [`NIB_XLEN-1:0] expected;
    logic [`NIB_XLEN-1:0] actual;
    nib_pkg::alu_op_e     op_q;
    nib_pkg::reg_idx_t    rd_q;
    string                name;
    logic                 pending = 1'b0;
    logic                 idle_err = 1'b0;
    int                   lat;
    int                   first_lat;
    int                   nibs;
    int                   pass_count = 0;
    int                   fail_count = 0;
    int                   accepted = 0;
    int                   ignored = 0;

    initial begin
        for (int i = 0; i < `NIB_NUM_REGS; i++) begin
            model[i] = '0;
        end
    end

    function automatic logic [`NIB_XLEN-1:0] alu_model(input nib_pkg::alu_op_e op,
                                                       input logic [`NIB_XLEN-1:0] a,
                                                       input logic [`NIB_XLEN-1:0] b);
        case (op)
            nib_pkg::ALU_ADD:  return a + b;
            nib_pkg::ALU_SUB:  return a - b;
            nib_pkg::ALU_AND:  return a & b;
            nib_pkg::ALU_OR:   return a | b;
            nib_pkg::ALU_XOR:  return a ^ b;
            nib_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 1 : 0;
            nib_pkg::ALU_SLTU: return (a < b) ? 1 : 0;
            default:           return 'x;
        endcase
    endfunction

    task automatic start_instr();
        logic [`NIB_XLEN-1:0] b;
        b = instr_use_imm ? {{(`NIB_XLEN-12){instr_imm[11]}}, instr_imm} : model[instr_rs2];
        expected = alu_model(instr_op, model[instr_rs1], b);
        op_q     = instr_op;
        rd_q     = instr_rd;
        name     = $sformatf("%s%s #%0d", instr_op.name(), instr_use_imm ? "I" : "", accepted);
        accepted++;
        pending   = 1'b1;
        lat       = 0;
        first_lat = 0;
        nibs      = 0;
        actual    = '0;
    endtask

    task automatic finish_instr();
        int min_lat;
        // Set-less-than writes only in the second pass
        min_lat = (op_q == nib_pkg::ALU_SLT || op_q == nib_pkg::ALU_SLTU) ? `NIB_STEPS + 1 : 1;
        if (nibs != `NIB_STEPS || first_lat < min_lat || first_lat >= min_lat + `NIB_STEPS
            || lat != first_lat + `NIB_STEPS - 1) begin
            $display("%s: wrong writeback timing, %0d nibbles, first after %0d, done after %0d",
                     name, nibs, first_lat, lat);
            fail_count++;
        end else if (actual !== expected) begin
            $display("mismatch %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            fail_count++;
        end else begin
            $display("ok %s: x%0d = 0x%08h", name, rd_q, actual);
            pass_count++;
        end
        if (rd_q != '0) model[rd_q] = expected;
        pending = 1'b0;
    endtask

    always @(posedge clk) begin
        if (rstn) begin
            if (accepted == 0 && (busy || done || wb_en) && !idle_err) begin
                $display("busy, done or wb_en high after reset before any instruction");
                idle_err = 1'b1;
                fail_count++;
            end
            if (pending) begin
                lat++;
                if (wb_en) begin
                    if (nibs == 0) first_lat = lat;
                    if (nibs < `NIB_STEPS) actual[4*nibs +: 4] = wb_data;   // Low nibble first
                    nibs++;
                end
                if (done) begin
                    finish_instr();
                end else if (!busy) begin
                    $display("%s: busy fell before done, instruction never completed", name);
                    fail_count++;
                    pending = 1'b0;
                end
            end
            if (instr_valid && busy) begin
                ignored++;
                $display("strobe while busy dropped");
            end else if (instr_valid) begin
                start_instr();
            end
        end
    end

endmodule

// ==== dv/nib_core_tb.sv ====
// Testbench top with clock, reset, seeded random instruction driver, DUT, checker and summary
`timescale 1ns/100ps
`include "nib_macros.svh"

module nib_core_tb;

    localparam int NUM_INSTR   = 300;
    localparam int CYCLE_LIMIT = NUM_INSTR * 32 + 100;

    logic              clk = 1'b0;
    logic              rstn;
    logic              instr_valid;
    nib_pkg::alu_op_e  instr_op;
    nib_pkg::reg_idx_t instr_rd;
    nib_pkg::reg_idx_t instr_rs1;
    nib_pkg::reg_idx_t instr_rs2;
    nib_pkg::imm12_t   instr_imm;
    logic              instr_use_imm;
    logic              busy;
    logic              done;
    logic              wb_en;
    logic [3:0]        wb_data;

    integer seed = 9901;
    int     issued = 0;
    int     last_rd = 0;
    int     cycles = 0;
    int     total_fail;

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, instructions stopped completing", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    nib_core nib_core_i (.*);

    nib_core_checker checker_i (.*);

    // Strobe one instruction on a falling edge once the core is idle
    task automatic issue_instr(input nib_pkg::alu_op_e op, input int rd, input int rs1,
                               input int rs2, input int imm, input logic use_imm,
                               input int gap);
        while (busy) @(negedge clk);
        repeat (gap) @(negedge clk);
        instr_valid   = 1'b1;
        instr_op      = op;
        instr_rd      = nib_pkg::reg_idx_t'(rd);
        instr_rs1     = nib_pkg::reg_idx_t'(rs1);
        instr_rs2     = nib_pkg::reg_idx_t'(rs2);
        instr_imm     = nib_pkg::imm12_t'(imm);
        instr_use_imm = use_imm;
        issued++;
        last_rd = rd;
        @(negedge clk);
        instr_valid = 1'b0;
    endtask

    task automatic random_instr();
        nib_pkg::alu_op_e op;
        int               rd;
        int               rs1;
        int               gap;
        op  = nib_pkg::alu_op_e'({$random(seed)} % 7);
        rd  = {$random(seed)} % `NIB_NUM_REGS;
        rs1 = ({$random(seed)} % 3 == 0) ? last_rd : {$random(seed)} % `NIB_NUM_REGS;  // Dependency
        gap = ({$random(seed)} % 6 == 0) ? 1 + {$random(seed)} % 3 : 0;
        issue_instr(op, rd, rs1, {$random(seed)} % `NIB_NUM_REGS,
                    {$random(seed)} % 4096 - 2048, $random(seed), gap);
    endtask

    // Extra strobe a few cycles into an instruction, must be dropped
    task automatic strobe_while_busy();
        repeat (2) @(negedge clk);
        instr_valid = 1'b1;
        instr_op    = nib_pkg::ALU_XOR;
        instr_rd    = nib_pkg::reg_idx_t'(last_rd);
        instr_imm   = nib_pkg::imm12_t'($random(seed));
        @(negedge clk);
        instr_valid = 1'b0;
    endtask

    initial begin
        rstn          = 1'b0;
        instr_valid   = 1'b0;
        instr_op      = nib_pkg::ALU_ADD;
        instr_rd      = '0;
        instr_rs1     = '0;
        instr_rs2     = '0;
        instr_imm     = '0;
        instr_use_imm = 1'b0;
        repeat (16) @(negedge clk);
        rstn = 1'b1;
        repeat (4) @(negedge clk);   // Idle outputs watched here

        // x1 all ones, x2 doubled up to the most negative value
        issue_instr(nib_pkg::ALU_ADD, 1, 0, 0, -1, 1'b1, 0);
        issue_instr(nib_pkg::ALU_ADD, 2, 0, 0, 1, 1'b1, 0);
        for (int i = 0; i < 31; i++) begin
            issue_instr(nib_pkg::ALU_ADD, 2, 2, 2, 0, 1'b0, 0);
        end
        issue_instr(nib_pkg::ALU_ADD, 0, 0, 0, 5, 1'b1, 0);
        issue_instr(nib_pkg::ALU_OR, 3, 0, 0, 0, 1'b0, 0);
        issue_instr(nib_pkg::ALU_SLT, 4, 2, 1, 0, 1'b0, 0);
        issue_instr(nib_pkg::ALU_SLTU, 4, 2, 1, 0, 1'b0, 0);
        issue_instr(nib_pkg::ALU_SLT, 4, 1, 2, 0, 1'b0, 0);
        issue_instr(nib_pkg::ALU_SLTU, 4, 1, 1, 0, 1'b0, 0);
        issue_instr(nib_pkg::ALU_SLT, 4, 2, 2, 0, 1'b0, 0);
        issue_instr(nib_pkg::ALU_SLT, 5, 2, 0, -2048, 1'b1, 0);
        issue_instr(nib_pkg::ALU_SLTU, 5, 1, 0, -1, 1'b1, 0);
        issue_instr(nib_pkg::ALU_SLTU, 5, 0, 1, 0, 1'b0, 0);

        while (issued < NUM_INSTR) begin
            random_instr();
            if (issued == NUM_INSTR / 2) strobe_while_busy();
        end
        while (busy) @(negedge clk);
        repeat (2) @(negedge clk);

        total_fail = checker_i.fail_count + nib_core_i.core_assert_i.fail_count;
        if (checker_i.accepted != NUM_INSTR || checker_i.ignored != 1) begin
            $display("wrong instruction count, %0d accepted and %0d dropped, expected %0d and 1",
                     checker_i.accepted, checker_i.ignored, NUM_INSTR);
            total_fail++;
        end
        $display("passed %0d, failed %0d", checker_i.pass_count, total_fail);
        if (total_fail == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== nib_core.f ====
+incdir+include
source/nib_pkg.sv
source/nib_exec_if.sv
source/nib_issue.sv
source/nib_regfile.sv
source/nib_alu_exec.sv
source/nib_core.sv
dv/nib_core_assert.sv
dv/nib_core_checker.sv
dv/nib_core_tb.sv

// ==== Bender.yml ====
package:
  name: nib_core

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/nib_pkg.sv
      - source/nib_exec_if.sv
      - source/nib_issue.sv
      - source/nib_regfile.sv
      - source/nib_alu_exec.sv
      - source/nib_core.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/nib_core_assert.sv
      - dv/nib_core_checker.sv
      - dv/nib_core_tb.sv
